// File: src.f
source/coreMemPkg.sv
source/dualPortMem.sv
source/instrFetch.sv
source/coreDataPort.sv
source/fabricInbound.sv
source/transFifo.sv
source/fabricEgress.sv
source/coreMemWrap.sv
verification/coreMemChecker.sv
verification/coreMemWrap_properties.sv
verification/coreMemWrapTb.sv

// File: Bender.yml
package:
  name: core_mem_wrap

sources:
  - files:
      - source/coreMemPkg.sv
      - source/dualPortMem.sv
      - source/instrFetch.sv
      - source/coreDataPort.sv
      - source/fabricInbound.sv
      - source/transFifo.sv
      - source/fabricEgress.sv
      - source/coreMemWrap.sv
  - target: test
    files:
      - verification/coreMemChecker.sv
      - verification/coreMemWrap_properties.sv
      - verification/coreMemWrapTb.sv

// File: verification/coreMemWrapTb.sv
`timescale 1ns/1ps

module coreMemWrapTb;
    import coreMemPkg::*;

    localparam int ResetCycles = 10;
    localparam int WaitLimit   = 20;  // Worst case cycles per entry
    localparam logic [2:0] ModeNone  = 3'd0;
    localparam logic [2:0] ModeInstr = 3'd1;
    localparam logic [2:0] ModeData  = 3'd2;
    localparam logic [2:0] ModeReady = 3'd3;
    localparam logic [2:0] ModeOut   = 3'd4;
    localparam logic [2:0] ModeMcr   = 3'd5;

    typedef enum {CoreWr, CoreRd, FabWr, FabRd, RdRsp, FabMask,
                  Fetch, Stall, Idle, ReadyChk, OutChk} kind_t;

    typedef struct {
        kind_t       kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  byteEn;
        logic [7:0]  reqId;
        logic [2:0]  mode;
        logic [31:0] exp;
        tileTrans_t  expTrans;
    } entry_t;

    logic                     Clock;
    logic                     rst;
    logic [TileIdWidth-1:0]   localTileId;
    logic                     ready;
    logic [31:0]              pc;
    logic [31:0]              instruction;
    coreDataReq_t             coreDataReq;
    logic [31:0]              dataRdRsp;
    logic                     dataReady;
    logic                     inFabricValid;
    tileTrans_t               inFabric;
    logic                     miniCoreReady;
    logic                     outFabricValid;
    tileTrans_t               outFabric;
    logic [FabReadyWidth-1:0] fabReady;

    logic        chkStrobe;
    logic [2:0]  chkMode;
    int          testIdx;
    logic [31:0] expWord;
    tileTrans_t  expTrans;
    logic        reportStrobe;
    logic        checkBusy;
    int          errCount;
    int          cycleCount;
    int          timeoutLimit;
    entry_t      stimTable[$];

    coreMemWrap u_dut (.*);

    coreMemChecker uChecker (
        .Clock (Clock), .chkStrobe (chkStrobe), .chkMode (chkMode),
        .testIdx (testIdx), .expWord (expWord), .expTrans (expTrans),
        .reportStrobe (reportStrobe), .instruction (instruction),
        .dataRdRsp (dataRdRsp), .dataReady (dataReady),
        .miniCoreReady (miniCoreReady),
        .outFabricValid (outFabricValid), .outFabric (outFabric),
        .busy (checkBusy), .errCount (errCount)
    );

    always #50 Clock = ~Clock;  // 100 ns period

    // Run limit from table length
    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount >= timeoutLimit) begin
            $display("Timeout after %0d cycles", cycleCount);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic tileTrans_t makeTrans(input logic [31:0] addr, input logic [31:0] data,
                                             input opcode_t op, input logic [7:0] reqId);
        tileTrans_t t;
        t.address     = addr;
        t.data        = data;
        t.opcode      = op;
        t.requestorId = reqId;
        return t;
    endfunction

    task automatic addEntry(input kind_t kind, input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] byteEn, input logic [7:0] reqId,
                            input logic [2:0] mode, input logic [31:0] exp,
                            input tileTrans_t expT);
        entry_t e;
        e = '{kind, addr, data, byteEn, reqId, mode, exp, expT};
        stimTable.push_back(e);
    endtask

    // ==================================================
    // Apply one entry, starting and ending on a falling edge
    // ==================================================
    task automatic applyEntry(input int idx, input entry_t e);
        case (e.kind)
            CoreWr, CoreRd: begin
                while (!dataReady) @(negedge Clock);  // Core holds until ready
                coreDataReq.address = e.addr;
                coreDataReq.wrData  = e.data;
                coreDataReq.byteEn  = e.byteEn;
                coreDataReq.wrEn    = (e.kind == CoreWr);
                coreDataReq.rdEn    = (e.kind == CoreRd);
                @(negedge Clock);
                coreDataReq = '0;
            end
            FabWr, FabRd, RdRsp: begin
                inFabric.address     = e.addr;
                inFabric.data        = e.data;
                inFabric.requestorId = e.reqId;
                case (e.kind)
                    FabWr:   inFabric.opcode = WR;
                    FabRd:   inFabric.opcode = RD;
                    default: inFabric.opcode = RD_RSP;
                endcase
                inFabricValid = 1'b1;
                @(negedge Clock);
                inFabricValid = 1'b0;
            end
            FabMask: fabReady = e.data[FabReadyWidth-1:0];
            Fetch, Stall: begin
                pc    = e.addr;
                ready = (e.kind == Fetch);
                @(negedge Clock);
            end
            Idle: @(negedge Clock);  // Let a queued response settle
            default: ;  // Check only
        endcase
        if (e.mode != ModeNone) begin
            testIdx   = idx;
            chkMode   = e.mode;
            expWord   = e.exp;
            expTrans  = e.expTrans;
            chkStrobe = 1'b1;
            @(negedge Clock);
            chkStrobe = 1'b0;
            while (checkBusy) @(negedge Clock);
        end
        ready = 1'b1;
    endtask

    task automatic buildTable(input logic [7:0] lt);
        logic [31:0] w [8];
        logic [7:0]  rt;
        logic [31:0] merged;
        tileTrans_t  none;
        none = '0;
        rt   = 8'h05;  // Remote tile, never equal to lt
        for (int i = 0; i < 8; i++) w[i] = $urandom;
        merged = {w[3][15:0], w[2][7:0], w[1][7:0]};
        // Instruction path
        addEntry(FabWr, {lt, 24'h010010}, w[0], 4'h0, lt, ModeNone, 0, none);
        addEntry(Fetch, 32'h10, 0, 4'h0, 0, ModeInstr, w[0], none);
        addEntry(Stall, 32'h14, 0, 4'h0, 0, ModeInstr, w[0], none);
        // Byte and half writes
        addEntry(CoreWr, {lt, 24'h000100}, w[1], 4'hf, 0, ModeNone, 0, none);
        addEntry(CoreWr, {lt, 24'h000101}, {24'h0, w[2][7:0]}, 4'h1, 0, ModeNone, 0, none);
        addEntry(CoreWr, {lt, 24'h000102}, {16'h0, w[3][15:0]}, 4'h3, 0, ModeNone, 0, none);
        addEntry(CoreRd, {lt, 24'h000100}, 0, 4'hf, 0, ModeData, merged, none);
        addEntry(CoreRd, {lt, 24'h000103}, 0, 4'h1, 0, ModeData, {24'h0, merged[31:24]}, none);
        // Fabric reads, hit and miss
        addEntry(FabRd, {lt, 24'h020100}, 0, 4'h0, rt, ModeOut, 0,
                 makeTrans({rt, 24'h020100}, merged, RD_RSP, lt));
        addEntry(FabRd, {lt, 24'h070100}, 0, 4'h0, rt, ModeOut, 0,
                 makeTrans({rt, 24'h070100}, 32'h0, RD_RSP, lt));
        // Response held by a closed lane throttles the sender
        addEntry(FabMask, 0, 32'h7, 4'h0, 0, ModeNone, 0, none);
        addEntry(FabRd, {lt, 24'h010010}, 0, 4'h0, rt, ModeNone, 0, none);
        addEntry(Idle, 0, 0, 4'h0, 0, ModeMcr, 0, none);
        addEntry(FabMask, 0, 32'hf, 4'h0, 0, ModeNone, 0, none);
        addEntry(OutChk, 0, 0, 4'h0, 0, ModeOut, 0,
                 makeTrans({rt, 24'h010010}, w[0], RD_RSP, lt));
        addEntry(ReadyChk, 0, 0, 4'h0, 0, ModeMcr, 1, none);
        // Remote write and read
        addEntry(CoreWr, {rt, 24'h000200}, w[4], 4'hf, 0, ModeOut, 0,
                 makeTrans({rt, 24'h000200}, w[4], WR, lt));
        addEntry(CoreRd, {rt, 24'h000300}, 0, 4'hf, 0, ModeOut, 0,
                 makeTrans({rt, 24'h000300}, 32'h0, RD, lt));
        addEntry(ReadyChk, 0, 0, 4'h0, 0, ModeReady, 0, none);
        addEntry(RdRsp, {lt, 24'h000300}, w[5], 4'h0, lt, ModeData, w[5], none);
        addEntry(ReadyChk, 0, 0, 4'h0, 0, ModeReady, 1, none);
        // Back-pressure on one lane
        addEntry(FabMask, 0, 32'hb, 4'h0, 0, ModeNone, 0, none);
        addEntry(CoreWr, {rt, 24'h000400}, w[6], 4'hf, 0, ModeNone, 0, none);
        addEntry(CoreWr, {rt, 24'h000404}, w[7], 4'hf, 0, ModeNone, 0, none);
        addEntry(ReadyChk, 0, 0, 4'h0, 0, ModeReady, 0, none);
        addEntry(FabMask, 0, 32'hf, 4'h0, 0, ModeNone, 0, none);
        addEntry(OutChk, 0, 0, 4'h0, 0, ModeOut, 0,
                 makeTrans({rt, 24'h000400}, w[6], WR, lt));
        addEntry(OutChk, 0, 0, 4'h0, 0, ModeOut, 0,
                 makeTrans({rt, 24'h000404}, w[7], WR, lt));
    endtask

    initial begin
        void'($urandom(32'he2ea));
        Clock         = 1'b0;
        rst           = 1'b1;
        localTileId   = 8'h10 + ($urandom % 8'hc0);  // Never 0 or the remote tile
        ready         = 1'b1;
        pc            = '0;
        coreDataReq   = '0;
        inFabricValid = 1'b0;
        inFabric      = '0;
        fabReady      = '1;
        chkStrobe     = 1'b0;
        chkMode       = ModeNone;
        testIdx       = 0;
        expWord       = '0;
        expTrans      = '0;
        reportStrobe  = 1'b0;
        cycleCount    = 0;
        buildTable(localTileId);
        timeoutLimit = stimTable.size() * WaitLimit + ResetCycles;

        repeat (ResetCycles) @(posedge Clock);
        @(negedge Clock);
        rst = 1'b0;
        @(negedge Clock);

        foreach (stimTable[i]) applyEntry(i, stimTable[i]);

        reportStrobe = 1'b1;
        @(negedge Clock);
        reportStrobe = 1'b0;
        if (errCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: verification/coreMemWrap_properties.sv
`timescale 1ns/1ps

module coreMemWrapProperties
    import coreMemPkg::*;
(
    input logic                     Clock,
    input logic                     rst,
    input logic                     dataReady,
    input logic                     outFabricValid,
    input logic [FabReadyWidth-1:0] fabReady,
    input logic                     reqFull
);

    // Nothing leaves while any lane is closed
    assert property (@(posedge Clock) disable iff (rst) outFabricValid |-> &fabReady)
        else $error("outFabricValid with fabReady %h", fabReady);

    // First cycle out of reset
    assert property (@(posedge Clock) $fell(rst) |-> dataReady && !outFabricValid)
        else $error("Bad state after reset");

    assert property (@(posedge Clock) disable iff (rst) reqFull |-> !dataReady)
        else $error("dataReady high with request queue full");

endmodule

bind coreMemWrap coreMemWrapProperties uProps (
    .Clock          (Clock),
    .rst            (rst),
    .dataReady      (dataReady),
    .outFabricValid (outFabricValid),
    .fabReady       (fabReady),
    .reqFull        (reqFull)
);

// File: verification/coreMemChecker.sv
`timescale 1ns/1ps

module coreMemChecker
    import coreMemPkg::*;
(
    input  logic        Clock,
    input  logic        chkStrobe,     // One cycle, raised on falling edge
    input  logic [2:0]  chkMode,
    input  int          testIdx,
    input  logic [31:0] expWord,
    input  tileTrans_t  expTrans,
    input  logic        reportStrobe,
    input  logic [31:0] instruction,
    input  logic [31:0] dataRdRsp,
    input  logic        dataReady,
    input  logic        miniCoreReady,
    input  logic        outFabricValid,
    input  tileTrans_t  outFabric,
    output logic        busy,
    output int          errCount
);

    localparam logic [2:0] ModeInstr = 3'd1;
    localparam logic [2:0] ModeData  = 3'd2;
    localparam logic [2:0] ModeReady = 3'd3;
    localparam logic [2:0] ModeOut   = 3'd4;
    localparam logic [2:0] ModeMcr   = 3'd5;
    localparam int OutWaitLimit = 16;  // Cycles to wait for an outFabric strobe

    int passCount;
    int waitCount;
    int curIdx;

    initial begin
        busy      = 1'b0;
        errCount  = 0;
        passCount = 0;
        waitCount = 0;
        curIdx    = 0;
    end

    // Wide enough for a whole transaction
    task automatic compareValue(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        if (got === exp) begin
            passCount++;
            $display("PASS test %0d: %s = %0h", curIdx, name, got);
        end else begin
            errCount++;
            $display("FAIL test %0d: %s got %0h expected %0h", curIdx, name, got, exp);
        end
    endtask

    // ==================================================
    // Sampling on rising edge, before the edge's updates
    // ==================================================
    always @(posedge Clock) begin
        if (busy) begin
            if (outFabricValid) begin
                compareValue("outFabric", 128'(outFabric), 128'(expTrans));
                busy = 1'b0;
            end else if (waitCount >= OutWaitLimit) begin
                errCount++;
                $display("Test %0d failed: no transaction left on outFabric within %0d cycles",
                         curIdx, OutWaitLimit);
                busy = 1'b0;
            end else begin
                waitCount++;
            end
        end else if (chkStrobe) begin
            curIdx = testIdx;
            case (chkMode)
                ModeInstr: compareValue("instruction", 128'(instruction), 128'(expWord));
                ModeData:  compareValue("dataRdRsp", 128'(dataRdRsp), 128'(expWord));
                ModeReady: compareValue("dataReady", 128'(dataReady), 128'(expWord[0]));
                ModeMcr:   compareValue("miniCoreReady", 128'(miniCoreReady),
                                        128'(expWord[0]));
                ModeOut: begin
                    if (outFabricValid) begin
                        compareValue("outFabric", 128'(outFabric), 128'(expTrans));
                    end else begin
                        waitCount = 1;
                        busy = 1'b1;  // Keep watching
                    end
                end
                default: ;
            endcase
        end
        if (reportStrobe) begin
            $display("Checks finished: %0d passed, %0d failed", passCount, errCount);
        end
    end

endmodule

// File: source/coreMemWrap.sv
`timescale 1ns/1ps

module coreMemWrap
    import coreMemPkg::*;
(
    input  logic                     Clock,
    input  logic                     rst,
    input  logic [TileIdWidth-1:0]   localTileId,    // Strap
    // ==================================================
    // Core instruction and data
    // ==================================================
    input  logic                     ready,
    input  logic [31:0]              pc,
    output logic [31:0]              instruction,
    input  coreDataReq_t             coreDataReq,
    output logic [31:0]              dataRdRsp,
    output logic                     dataReady,
    // ==================================================
    // Fabric side
    // ==================================================
    input  logic                     inFabricValid,
    input  tileTrans_t               inFabric,
    output logic                     miniCoreReady,
    output logic                     outFabricValid,
    output tileTrans_t               outFabric,
    input  logic [FabReadyWidth-1:0] fabReady
);

    memPortB_t   iMemPort;
    memPortB_t   dMemPort;
    logic [31:0] iMemRdData;
    logic [31:0] dMemRdData;
    logic        rdRspHit;
    logic        rspValid;
    tileTrans_t  rsp;
    tileTrans_t  remoteReq;
    logic        remoteReqValid;
    logic        reqFull;
    logic        rspAlmostFull;

    instrFetch uInstrFetch (
        .Clock        (Clock),
        .ready        (ready),
        .pc           (pc),
        .fabricPort   (iMemPort),
        .instruction  (instruction),
        .fabricRdData (iMemRdData)
    );

    coreDataPort uCoreDataPort (
        .Clock          (Clock),
        .rst            (rst),
        .localTileId    (localTileId),
        .coreDataReq    (coreDataReq),
        .rdRspHit       (rdRspHit),
        .rdRspData      (inFabric.data),    // Payload of inbound RD_RSP
        .reqFull        (reqFull),
        .fabricPort     (dMemPort),
        .dataRdRsp      (dataRdRsp),
        .dataReady      (dataReady),
        .remoteReq      (remoteReq),
        .remoteReqValid (remoteReqValid),
        .fabricRdData   (dMemRdData)
    );

    fabricInbound uFabricInbound (
        .Clock         (Clock),
        .localTileId   (localTileId),
        .inFabricValid (inFabricValid),
        .inFabric      (inFabric),
        .iMemRdData    (iMemRdData),
        .dMemRdData    (dMemRdData),
        .iMemPort      (iMemPort),
        .dMemPort      (dMemPort),
        .rdRspHit      (rdRspHit),
        .rspValid      (rspValid),
        .rsp           (rsp)
    );

    fabricEgress uFabricEgress (
        .Clock          (Clock),
        .rst            (rst),
        .rspValid       (rspValid),
        .rsp            (rsp),
        .remoteReqValid (remoteReqValid),
        .remoteReq      (remoteReq),
        .fabReady       (fabReady),
        .reqFull        (reqFull),
        .rspAlmostFull  (rspAlmostFull),
        .outFabricValid (outFabricValid),
        .outFabric      (outFabric)
    );

    assign miniCoreReady = !rspAlmostFull;  // Throttle sender with one slot margin

endmodule

// File: source/fabricEgress.sv
`timescale 1ns/1ps

module fabricEgress
    import coreMemPkg::*;
(
    input  logic                     Clock,
    input  logic                     rst,
    input  logic                     rspValid,
    input  tileTrans_t               rsp,
    input  logic                     remoteReqValid,
    input  tileTrans_t               remoteReq,
    input  logic [FabReadyWidth-1:0] fabReady,
    output logic                     reqFull,
    output logic                     rspAlmostFull,
    output logic                     outFabricValid,
    output tileTrans_t               outFabric
);

    tileTrans_t rspHead;
    tileTrans_t reqHead;
    logic       rspEmpty;
    logic       reqEmpty;
    logic       rspCand;
    logic       reqCand;
    logic       grantRsp;
    logic       grantReq;
    logic       favorReq;  // Round-robin pointer

    // ==================================================
    // Response and request queues
    // ==================================================
    transFifo #(.Depth(TransFifoDepth)) uRspQueue (
        .Clock (Clock), .rst (rst),
        .push (rspValid), .pushData (rsp),
        .pop (grantRsp), .popData (rspHead),
        .full (), .almostFull (rspAlmostFull), .empty (rspEmpty)
    );

    transFifo #(.Depth(TransFifoDepth)) uReqQueue (
        .Clock (Clock), .rst (rst),
        .push (remoteReqValid), .pushData (remoteReq),
        .pop (grantReq), .popData (reqHead),
        .full (reqFull), .almostFull (), .empty (reqEmpty)
    );

    // All fabric lanes must be open
    assign rspCand  = !rspEmpty && (&fabReady);
    assign reqCand  = !reqEmpty && (&fabReady);
    assign grantReq = reqCand && (favorReq || !rspCand);
    assign grantRsp = rspCand && !grantReq;

    always_ff @(posedge Clock) begin
        if (rst) begin
            favorReq <= 1'b0;
        end else if (grantRsp) begin
            favorReq <= 1'b1;  // Flip after each grant
        end else if (grantReq) begin
            favorReq <= 1'b0;
        end
    end

    assign outFabricValid = grantRsp || grantReq;
    assign outFabric      = grantRsp ? rspHead :
                            grantReq ? reqHead :
                                       '0;

endmodule

// File: source/transFifo.sv
`timescale 1ns/1ps

module transFifo
    import coreMemPkg::*;
#(
    parameter int Depth = 2
) (
    input  logic       Clock,
    input  logic       rst,
    input  logic       push,
    input  tileTrans_t pushData,
    input  logic       pop,
    output tileTrans_t popData,
    output logic       full,
    output logic       almostFull,
    output logic       empty
);

    tileTrans_t                 entries [Depth];
    logic [$clog2(Depth)-1:0]   wrPtr;
    logic [$clog2(Depth)-1:0]   rdPtr;
    logic [$clog2(Depth):0]     count;
    logic                       doPush;
    logic                       doPop;

    assign doPush = push && !full;   // Ignored when full
    assign doPop  = pop && !empty;

    always_ff @(posedge Clock) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= (wrPtr == Depth - 1) ? '0 : wrPtr + 1'b1;
            if (doPop)  rdPtr <= (rdPtr == Depth - 1) ? '0 : rdPtr + 1'b1;
            count <= count + doPush - doPop;
        end
    end

    always_ff @(posedge Clock) begin
        if (doPush) entries[wrPtr] <= pushData;
    end

    assign popData    = entries[rdPtr];  // Head, valid when not empty
    assign full       = (count == Depth);
    assign almostFull = (count >= Depth - 1);  // One slot or less left
    assign empty      = (count == 0);

endmodule

// File: source/fabricInbound.sv
`timescale 1ns/1ps

module fabricInbound
    import coreMemPkg::*;
(
    input  logic                   Clock,
    input  logic [TileIdWidth-1:0] localTileId,
    input  logic                   inFabricValid,
    input  tileTrans_t             inFabric,
    input  logic [31:0]            iMemRdData,
    input  logic [31:0]            dMemRdData,
    output memPortB_t              iMemPort,
    output memPortB_t              dMemPort,
    output logic                   rdRspHit,
    output logic                   rspValid,
    output tileTrans_t             rsp
);

    logic [7:0] region;
    logic       iMemHit;
    logic       dMemHit;
    logic       isWrite;
    logic       rdReq;
    logic       iMemHitQ;   // Q504 hit flags
    logic       dMemHitQ;
    tileAddr_t  rspAddrQ;

    // ==================================================
    // Q503 region decode
    // ==================================================
    assign region  = inFabric.address.regionView.region;
    assign iMemHit = (region > IMemRegionFloor) && (region < IMemRegionRoof);
    assign dMemHit = (region > DMemRegionFloor) && (region < DMemRegionRoof);
    assign isWrite = inFabricValid && (inFabric.opcode == WR);
    assign rdReq   = inFabricValid && (inFabric.opcode == RD);
    assign rdRspHit = inFabricValid && (inFabric.opcode == RD_RSP);  // Core side qualifies

    // Both ports read every cycle, words return at Q504
    assign iMemPort.wordAddr = inFabric.address.regionView.offset[MemWordAddrBits+1:2];
    assign iMemPort.data     = inFabric.data;
    assign iMemPort.wrEn     = isWrite && iMemHit;
    assign dMemPort.wordAddr = inFabric.address.regionView.offset[MemWordAddrBits+1:2];
    assign dMemPort.data     = inFabric.data;
    assign dMemPort.wrEn     = isWrite && dMemHit;

    // ==================================================
    // Q504 read response build
    // ==================================================
    always_ff @(posedge Clock) begin
        rspValid <= rdReq;
        iMemHitQ <= iMemHit;
        dMemHitQ <= dMemHit;
        rspAddrQ <= {inFabric.requestorId, inFabric.address.tileView.offset};  // Back to sender
    end

    assign rsp.address     = rspAddrQ;
    assign rsp.opcode      = RD_RSP;
    assign rsp.requestorId = localTileId;
    assign rsp.data        = iMemHitQ ? iMemRdData :
                             dMemHitQ ? dMemRdData :
                                        '0;  // Miss reads as zero

endmodule

// File: source/coreDataPort.sv
`timescale 1ns/1ps

module coreDataPort
    import coreMemPkg::*;
(
    input  logic                   Clock,
    input  logic                   rst,
    input  logic [TileIdWidth-1:0] localTileId,
    input  coreDataReq_t           coreDataReq,
    input  logic                   rdRspHit,
    input  logic [31:0]            rdRspData,
    input  logic                   reqFull,
    input  memPortB_t              fabricPort,
    output logic [31:0]            dataRdRsp,
    output logic                   dataReady,
    output tileTrans_t             remoteReq,
    output logic                   remoteReqValid,
    output logic [31:0]            fabricRdData
);

    logic        isLocal;
    logic        localWrEn;
    logic        remoteAccess;
    logic        outstandingRd;
    logic        rspTaken;
    logic        rspValidQ;     // Q504 fabric response strobe
    logic [31:0] rspDataQ;
    logic [31:0] shiftWrData;
    logic [3:0]  shiftByteEn;
    logic [31:0] memRdData;
    logic [1:0]  byteOffsetQ;   // Q104 copy of low address bits

    // ==================================================
    // Local / remote decode at Q103
    // ==================================================
    assign isLocal = (coreDataReq.address.tileView.tileId == localTileId) ||
                     (coreDataReq.address.tileView.tileId == '0);  // Tile 0 aliases self
    assign localWrEn    = coreDataReq.wrEn && isLocal;
    assign remoteAccess = (coreDataReq.wrEn || coreDataReq.rdEn) && !isLocal;
    assign rspTaken     = rdRspHit && outstandingRd;  // Only claim expected responses

    // Align byte/half writes to their lane
    assign shiftWrData = coreDataReq.wrData << {coreDataReq.address.tileView.offset[1:0], 3'b000};
    assign shiftByteEn = coreDataReq.byteEn << coreDataReq.address.tileView.offset[1:0];

    dualPortMem uDMem (
        .Clock     (Clock),
        .aWordAddr (coreDataReq.address.tileView.offset[MemWordAddrBits+1:2]),
        .aData     (shiftWrData),
        .aByteEn   (shiftByteEn),
        .aWrEn     (localWrEn),
        .aQ        (memRdData),
        .bWordAddr (fabricPort.wordAddr),
        .bData     (fabricPort.data),
        .bWrEn     (fabricPort.wrEn),
        .bQ        (fabricRdData)
    );

    // ==================================================
    // Remote requests and outstanding read
    // ==================================================
    always_comb begin
        remoteReq             = '0;
        remoteReq.address     = coreDataReq.address;
        remoteReq.data        = coreDataReq.wrData;  // Unshifted, remote tile aligns
        remoteReq.opcode      = coreDataReq.wrEn ? WR : RD;
        remoteReq.requestorId = localTileId;
    end

    assign remoteReqValid = remoteAccess && !outstandingRd && !reqFull;  // No push dropped

    always_ff @(posedge Clock) begin
        if (rst) begin
            outstandingRd <= 1'b0;
            rspValidQ     <= 1'b0;
        end else begin
            if (rspTaken) begin
                outstandingRd <= 1'b0;
            end else if (remoteReqValid && coreDataReq.rdEn) begin
                outstandingRd <= 1'b1;  // Block core until RD_RSP
            end
            rspValidQ <= rspTaken;
        end
    end

    always_ff @(posedge Clock) begin
        rspDataQ    <= rdRspData;
        byteOffsetQ <= coreDataReq.address.tileView.offset[1:0];
    end

    // Q104 read data, fabric response first
    assign dataRdRsp = rspValidQ ? rspDataQ : (memRdData >> {byteOffsetQ, 3'b000});
    assign dataReady = !outstandingRd && !reqFull;

endmodule

// File: source/instrFetch.sv
`timescale 1ns/1ps

module instrFetch
    import coreMemPkg::*;
(
    input  logic        Clock,
    input  logic        ready,
    input  logic [31:0] pc,
    input  memPortB_t   fabricPort,
    output logic [31:0] instruction,
    output logic [31:0] fabricRdData
);

    logic [31:0] fetchWord;  // Q101 raw read
    logic [31:0] lastFetch;
    logic        readyQ;

    // Core side is read only
    dualPortMem uIMem (
        .Clock     (Clock),
        .aWordAddr (pc[MemWordAddrBits+1:2]),
        .aData     ('0),
        .aByteEn   ('0),
        .aWrEn     (1'b0),
        .aQ        (fetchWord),
        .bWordAddr (fabricPort.wordAddr),
        .bData     (fabricPort.data),
        .bWrEn     (fabricPort.wrEn),
        .bQ        (fabricRdData)
    );

    // Hold last word seen while core was running
    always_ff @(posedge Clock) begin
        readyQ <= ready;
        if (readyQ) lastFetch <= fetchWord;
    end

    assign instruction = readyQ ? fetchWord : lastFetch;  // Stall replay

endmodule

// File: source/dualPortMem.sv
`timescale 1ns/1ps

module dualPortMem
    import coreMemPkg::*;
(
    input  logic                       Clock,
    input  logic [MemWordAddrBits-1:0] aWordAddr,
    input  logic [31:0]                aData,
    input  logic [3:0]                 aByteEn,
    input  logic                       aWrEn,
    output logic [31:0]                aQ,
    input  logic [MemWordAddrBits-1:0] bWordAddr,
    input  logic [31:0]                bData,
    input  logic                       bWrEn,
    output logic [31:0]                bQ
);

    logic [3:0][7:0] mem [2**MemWordAddrBits];  // Byte lanes per word

    always_ff @(posedge Clock) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (aWrEn && aByteEn[lane]) mem[aWordAddr][lane] <= aData[lane*8 +: 8];
        end
        if (bWrEn) mem[bWordAddr] <= bData;  // Port B wins on same-word clash
        aQ <= mem[aWordAddr];  // Read returns old word on collision
        bQ <= mem[bWordAddr];
    end

endmodule

// File: source/coreMemPkg.sv
package coreMemPkg;

    // ==================================================
    // Memory map and sizing
    // ==================================================
    localparam int TileIdWidth     = 8;
    localparam int MemWordAddrBits = 10;  // 1024 words, 4 KB per memory
    localparam int IMemRegionFloor = 0;   // Region 1 only
    localparam int IMemRegionRoof  = 2;
    localparam int DMemRegionFloor = 1;   // Regions 2 and 3
    localparam int DMemRegionRoof  = 4;
    localparam int FabReadyWidth   = 4;
    localparam int TransFifoDepth  = 2;

    // ==================================================
    // Fabric transaction types
    // ==================================================
    typedef enum logic [1:0] {
        RD     = 2'd0,
        WR     = 2'd1,
        RD_RSP = 2'd2
    } opcode_t;

    // Same word, core view vs fabric region view
    typedef union packed {
        struct packed {
            logic [TileIdWidth-1:0] tileId;
            logic [23:0]            offset;
        } tileView;
        struct packed {
            logic [TileIdWidth-1:0] tile;
            logic [7:0]             region;  // Bits 23:16
            logic [15:0]            offset;
        } regionView;
    } tileAddr_t;

    typedef struct packed {
        tileAddr_t              address;
        logic [31:0]            data;
        opcode_t                opcode;
        logic [TileIdWidth-1:0] requestorId;
    } tileTrans_t;

    // Core request at Q103
    typedef struct packed {
        tileAddr_t   address;
        logic [31:0] wrData;
        logic [3:0]  byteEn;
        logic        wrEn;
        logic        rdEn;
    } coreDataReq_t;

    typedef struct packed {
        logic [MemWordAddrBits-1:0] wordAddr;
        logic [31:0]                data;
        logic                       wrEn;
    } memPortB_t;

endpackage
